// ==== bev.f ====
hw/bev_pkg.sv
hw/bev_ctrl.sv
hw/bev_order_regs.sv
hw/bev_recipe.sv
hw/bev_dram_port.sv
hw/bev.sv
+incdir+verification
verification/bev_tb.sv

// ==== verification/bev_model.svh ====
`ifndef BEV_MODEL_SVH
`define BEV_MODEL_SVH

// One order as the testbench issues it
typedef struct packed {
    bev_pkg::action_t   act;
    bev_pkg::bev_type_t btype;
    bev_pkg::bev_size_t size;
    logic [3:0]         month;
    logic [4:0]         day;
    logic [7:0]         box;
    logic [3:0][11:0]   sup;
} order_t;

function automatic int cup_volume(input bev_pkg::bev_size_t s);
    case (s)
        bev_pkg::size_l: return 960;
        bev_pkg::size_m: return 720;
        default:         return 480;
    endcase
endfunction

// Nibbles are black tea, green tea, milk, pineapple juice
function automatic logic [15:0] recipe_quarters(input bev_pkg::bev_type_t t);
    case (t)
        bev_pkg::black_tea:           return 16'h4000;
        bev_pkg::milk_tea:            return 16'h3010;
        bev_pkg::extra_milk_tea:      return 16'h2020;
        bev_pkg::green_tea:           return 16'h0400;
        bev_pkg::green_milk_tea:      return 16'h0220;
        bev_pkg::pineapple_juice:     return 16'h0004;
        bev_pkg::super_pineapple_tea: return 16'h2002;
        default:                      return 16'h2011;
    endcase
endfunction

function automatic logic date_expired(input bev_pkg::bev_record_t r, input order_t o);
    return {r.month, r.day} < {4'd0, o.month, 3'd0, o.day};
endfunction

function automatic int lane_stock(input bev_pkg::bev_record_t r, input int lane);
    case (lane)
        0:       return int'(r.black_tea);
        1:       return int'(r.green_tea);
        2:       return int'(r.milk);
        default: return int'(r.pineapple_juice);
    endcase
endfunction

function automatic int lane_need(input order_t o, input int lane);
    logic [15:0] q;
    q = recipe_quarters(o.btype);
    return int'(q[15-4*lane -: 4]) * cup_volume(o.size) / 4;
endfunction

function automatic bev_pkg::bev_record_t set_lane(input bev_pkg::bev_record_t r,
                                                  input int lane, input int v);
    bev_pkg::bev_record_t n;
    n = r;
    case (lane)
        0:       n.black_tea       = v[11:0];
        1:       n.green_tea       = v[11:0];
        2:       n.milk            = v[11:0];
        default: n.pineapple_juice = v[11:0];
    endcase
    return n;
endfunction

function automatic bev_pkg::error_msg_t expected_err(input order_t o,
                                                     input bev_pkg::bev_record_t r);
    bev_pkg::error_msg_t e;
    int i;
    e = bev_pkg::no_err;
    if (o.act == bev_pkg::make_drink)
    begin
        if (date_expired(r, o))
            e = bev_pkg::no_exp;
        else
            for (i = 0; i < 4; i++)
                if (lane_stock(r, i) < lane_need(o, i))
                    e = bev_pkg::no_ing;
    end
    else if (o.act == bev_pkg::supply)
    begin
        for (i = 0; i < 4; i++)
            if (lane_stock(r, i) + int'(o.sup[i]) > 4095)
                e = bev_pkg::ing_of;
    end
    else if (date_expired(r, o))
        e = bev_pkg::no_exp;
    return e;
endfunction

function automatic bev_pkg::bev_record_t expected_record(input order_t o,
                                                         input bev_pkg::bev_record_t r);
    bev_pkg::bev_record_t n;
    int i;
    int v;
    n = r;
    for (i = 0; i < 4; i++)
    begin
        if (o.act == bev_pkg::make_drink)
            v = lane_stock(r, i) - lane_need(o, i);
        else
            v = lane_stock(r, i) + int'(o.sup[i]);
        if (v > 4095)
            v = 4095;
        n = set_lane(n, i, v);
    end
    // Supply stamps the delivery date
    if (o.act == bev_pkg::supply)
    begin
        n.month = {4'd0, o.month};
        n.day   = {3'd0, o.day};
    end
    return n;
endfunction

function automatic logic write_expected(input order_t o, input bev_pkg::error_msg_t e);
    return (o.act == bev_pkg::supply) || (o.act == bev_pkg::make_drink && e == bev_pkg::no_err);
endfunction

`endif

// ==== verification/bev_tb.sv ====
module bev_tb;

    localparam logic [31:0] SEED = 32'h89a0_6133;
    localparam int N_ORDERS = 300;
    localparam int TIMEOUT_CYCLES = 8 + N_ORDERS * 40;

    logic                  clk;
    logic                  inf;
    logic                  sel_action_valid;
    logic                  type_valid;
    logic                  size_valid;
    logic                  date_valid;
    logic                  box_no_valid;
    logic                  box_sup_valid;
    bev_pkg::order_word_t  d;
    bev_pkg::dram_rsp_t    dram_rsp;
    bev_pkg::bev_result_t  result;
    bev_pkg::dram_req_t    dram_req;

    logic [31:0]           stim_state = SEED;
    logic [31:0]           bridge_state = SEED ^ 32'h5a5a_c3c3;
    bev_pkg::bev_record_t  mem [256];
    bev_pkg::bev_record_t  model_mem [256];
    logic [1:0]            rd_pipe = 2'b00;
    logic                  outstanding = 1'b0;
    logic                  outstanding_read = 1'b0;
    int                    err_seen [4];

    `include "bev_model.svh"

    bev i_bev (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .d                (d),
        .dram_rsp         (dram_rsp),
        .result           (result),
        .dram_req         (dram_req)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int n);
        stim_state = lcg(stim_state);
        return int'(stim_state[31:8]) % n;
    endfunction

    function automatic logic [11:0] fill_amount();
        if (pick(4) == 0)
            return 12'(pick(1024));
        return 12'(pick(4096));
    endfunction

    function automatic string action_label(input bev_pkg::action_t a);
        case (a)
            bev_pkg::make_drink: return "make_drink";
            bev_pkg::supply:     return "supply";
            default:             return "check_valid_date";
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_err(input string name, input bev_pkg::error_msg_t exp,
                             input bev_pkg::error_msg_t got);
        if (got !== exp)
            abort_run($sformatf("MISMATCH %s err_msg expected %0d actual %0d", name, exp, got));
    endtask

    task automatic check_complete(input string name, input logic exp, input logic got);
        if (got !== exp)
            abort_run($sformatf("MISMATCH %s complete expected %b actual %b", name, exp, got));
    endtask

    task automatic check_record(input string name, input bev_pkg::bev_record_t exp,
                                input bev_pkg::bev_record_t got);
        if (got !== exp)
            abort_run($sformatf("MISMATCH %s record expected %h actual %h", name, exp, got));
    endtask

    task automatic check_addr(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
            abort_run($sformatf("MISMATCH %s addr expected %0d actual %0d", name, exp, got));
    endtask

    // 0 to 3 idle cycles, then a one-cycle strobe
    task automatic send_field(input int which, input bev_pkg::order_word_t w);
        int gap;
        gap = pick(4);
        repeat (gap)
        begin
            @(posedge clk);
            #5;
        end
        d = w;
        case (which)
            0: sel_action_valid = 1'b1;
            1: type_valid       = 1'b1;
            2: size_valid       = 1'b1;
            3: date_valid       = 1'b1;
            4: box_no_valid     = 1'b1;
            default: box_sup_valid = 1'b1;
        endcase
        @(posedge clk);
        #5;
        {sel_action_valid, type_valid, size_valid} = 3'b000;
        {date_valid, box_no_valid, box_sup_valid} = 3'b000;
        d = '0;
    endtask

    // Bridge memory answers each request once
    always
    begin : bridge
        bev_pkg::dram_req_t req;
        int                 delay;
        @(negedge clk);
        if (inf && dram_req.in_valid)
        begin
            req = dram_req;
            bridge_state = lcg(bridge_state);
            delay = 1 + int'(bridge_state[30:28]);
            repeat (delay) @(posedge clk);
            #5;
            if (dram_req.addr !== req.addr || dram_req.r_wb !== req.r_wb)
                abort_run("Bridge request fields changed before the response");
            dram_rsp.out_valid = 1'b1;
            if (req.r_wb)
                dram_rsp.data_r = mem[req.addr];
            else
            begin
                mem[req.addr] = dram_req.data_w;
                dram_rsp.data_r = dram_req.data_w;
            end
            @(posedge clk);
            #5;
            dram_rsp.out_valid = 1'b0;
        end
    end

    // Request ordering and result timing
    always @(negedge clk)
    begin
        if (inf)
        begin
            if (result.out_valid !== rd_pipe[1])
                abort_run("Result pulse is not two cycles after the read response");
            if (!result.out_valid && (result.err_msg !== bev_pkg::no_err || result.complete))
                abort_run("Result fields are not idle outside the result pulse");
            if (dram_req.in_valid && outstanding)
                abort_run("Bridge request issued before the previous response");
            rd_pipe = {rd_pipe[0], dram_rsp.out_valid && outstanding && outstanding_read};
            if (dram_rsp.out_valid)
                outstanding = 1'b0;
            if (dram_req.in_valid)
            begin
                outstanding      = 1'b1;
                outstanding_read = dram_req.r_wb;
            end
        end
    end

    initial
    begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run hung, orders not finished within %0d cycles", cycle_count);
        $display("sim failed");
        $fatal(1);
    end

    initial
    begin : stimulus
        order_t               o;
        bev_pkg::bev_record_t rec;
        bev_pkg::bev_record_t exp_rec;
        bev_pkg::error_msg_t  exp_err;
        logic                 write_exp;
        string                test_name;
        int                   n;
        int                   i;
        int                   missing;

        clk = 1'b0;
        inf = 1'b0;
        {sel_action_valid, type_valid, size_valid} = 3'b000;
        {date_valid, box_no_valid, box_sup_valid} = 3'b000;
        d = '0;
        dram_rsp = '0;
        for (i = 0; i < 4; i++)
            err_seen[i] = 0;
        for (i = 0; i < 256; i++)
        begin
            rec.black_tea       = fill_amount();
            rec.green_tea       = fill_amount();
            rec.milk            = fill_amount();
            rec.pineapple_juice = fill_amount();
            rec.month           = 8'(1 + pick(12));
            rec.day             = 8'(1 + pick(28));
            mem[i]       = rec;
            model_mem[i] = rec;
        end

        repeat (8) @(posedge clk);
        #5;
        inf = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            if (result.out_valid || dram_req.in_valid)
                abort_run("Result or bridge request active after reset with no order");
        end

        for (n = 0; n < N_ORDERS; n++)
        begin
            o.act   = bev_pkg::action_t'(pick(3));
            o.btype = bev_pkg::bev_type_t'(pick(8));
            o.size  = bev_pkg::bev_size_t'(pick(3));
            o.month = 4'(1 + pick(12));
            o.day   = 5'(1 + pick(28));
            o.box   = (pick(2) == 0) ? 8'(pick(256)) : 8'(pick(8));
            for (i = 0; i < 4; i++)
                o.sup[i] = (pick(2) == 0) ? 12'(pick(4096)) : 12'(pick(256));
            test_name = $sformatf("order %0d %s", n, action_label(o.act));

            rec       = model_mem[o.box];
            exp_err   = expected_err(o, rec);
            write_exp = write_expected(o, exp_err);
            exp_rec   = expected_record(o, rec);
            if (write_exp)
                model_mem[o.box] = exp_rec;
            err_seen[int'(exp_err)]++;

            @(posedge clk);
            #5;
            send_field(0, {10'd0, o.act});
            if (o.act == bev_pkg::make_drink)
            begin
                send_field(1, {9'd0, o.btype});
                send_field(2, {10'd0, o.size});
            end
            send_field(3, {3'd0, o.month, o.day});
            send_field(4, {4'd0, o.box});
            if (o.act == bev_pkg::supply)
                for (i = 0; i < 4; i++)
                    send_field(5, o.sup[i]);

            @(negedge clk);
            while (!dram_req.in_valid)
                @(negedge clk);
            if (!dram_req.r_wb)
                abort_run($sformatf("%s issued a write where a read was due", test_name));
            check_addr(test_name, o.box, dram_req.addr);

            while (!result.out_valid)
                @(negedge clk);
            check_err(test_name, exp_err, result.err_msg);
            check_complete(test_name, exp_err == bev_pkg::no_err, result.complete);

            @(negedge clk);
            if (write_exp)
            begin
                if (!dram_req.in_valid || dram_req.r_wb)
                    abort_run($sformatf("%s has no write-back after the result", test_name));
                check_addr(test_name, o.box, dram_req.addr);
                check_record(test_name, exp_rec, dram_req.data_w);
            end
            else if (dram_req.in_valid)
                abort_run($sformatf("%s issued a write with nothing to write", test_name));
        end

        while (outstanding)
            @(negedge clk);
        missing = -1;
        for (i = 0; i < 4; i++)
            if (err_seen[i] == 0)
                missing = i;
        if (missing >= 0)
            abort_run($sformatf("Error code %0d never occurred in the orders", missing));
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== hw/bev.sv ====
module bev (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  logic                  type_valid,
    input  logic                  size_valid,
    input  logic                  date_valid,
    input  logic                  box_no_valid,
    input  logic                  box_sup_valid,
    input  bev_pkg::order_word_t  d,
    input  bev_pkg::dram_rsp_t    dram_rsp,
    output bev_pkg::bev_result_t  result,
    output bev_pkg::dram_req_t    dram_req
);

    bev_pkg::capture_t                 capture;
    bev_pkg::action_t                  act;
    bev_pkg::bev_type_t                btype;
    bev_pkg::bev_size_t                size;
    logic [3:0]                        month;
    logic [4:0]                        day;
    logic [7:0]                        box_no;
    logic [3:0][bev_pkg::ING_W-1:0]    supplies;
    logic                              supplies_full;
    logic                              rd_start;
    logic                              wr_start;
    logic                              compute_en;
    logic                              write_pending;
    bev_pkg::bev_record_t              record;
    bev_pkg::error_msg_t               err_msg;
    logic                              complete;

    bev_ctrl i_ctrl (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .supplies_full    (supplies_full),
        .write_pending    (write_pending),
        .d                (d),
        .act              (act),
        .read_done        (dram_rsp.out_valid),
        .err_msg          (err_msg),
        .complete         (complete),
        .capture          (capture),
        .rd_start         (rd_start),
        .wr_start         (wr_start),
        .compute_en       (compute_en),
        .result           (result)
    );

    bev_order_regs i_order_regs (
        .clk           (clk),
        .inf           (inf),
        .capture       (capture),
        .d             (d),
        .act           (act),
        .btype         (btype),
        .size          (size),
        .month         (month),
        .day           (day),
        .box_no        (box_no),
        .supplies      (supplies),
        .supplies_full (supplies_full)
    );

    bev_recipe i_recipe (
        .clk        (clk),
        .act        (act),
        .btype      (btype),
        .size       (size),
        .month      (month),
        .day        (day),
        .supplies   (supplies),
        .dram_rsp   (dram_rsp),
        .compute_en (compute_en),
        .record     (record),
        .err_msg    (err_msg),
        .complete   (complete)
    );

    bev_dram_port i_dram_port (
        .clk           (clk),
        .inf           (inf),
        .rd_start      (rd_start),
        .wr_start      (wr_start),
        .box_no        (box_no),
        .record        (record),
        .dram_rsp      (dram_rsp),
        .dram_req      (dram_req),
        .write_pending (write_pending)
    );

endmodule

// ==== hw/bev_dram_port.sv ====
module bev_dram_port (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  rd_start,
    input  logic                  wr_start,
    input  logic [7:0]            box_no,
    input  bev_pkg::bev_record_t  record,
    input  bev_pkg::dram_rsp_t    dram_rsp,
    output bev_pkg::dram_req_t    dram_req,
    output logic                  write_pending
);

    logic       in_valid;
    logic       r_wb;
    logic [7:0] addr;

    // Address and direction latched at issue, box_no may move on
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            in_valid <= 1'b0;
            r_wb     <= 1'b0;
            addr     <= 8'd0;
        end
        else
        begin
            in_valid <= rd_start || wr_start;
            if (rd_start || wr_start)
            begin
                r_wb <= rd_start;
                addr <= box_no;
            end
        end
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            write_pending <= 1'b0;
        else if (wr_start)
            write_pending <= 1'b1;
        else if (dram_rsp.out_valid)
            write_pending <= 1'b0;
    end

    // Write data is the recipe's held record
    always_comb
    begin
        dram_req.in_valid = in_valid;
        dram_req.r_wb     = r_wb;
        dram_req.addr     = addr;
        dram_req.data_w   = record;
    end

    a_no_read_over_write: assert property (@(posedge clk) disable iff (!inf)
        rd_start |-> !write_pending);

    a_pulse_in_valid: assert property (@(posedge clk) disable iff (!inf)
        dram_req.in_valid |=> !dram_req.in_valid);

endmodule

// ==== hw/bev_recipe.sv ====
module bev_recipe (
    input  logic                              clk,
    input  bev_pkg::action_t                  act,
    input  bev_pkg::bev_type_t                btype,
    input  bev_pkg::bev_size_t                size,
    input  logic [3:0]                        month,
    input  logic [4:0]                        day,
    input  logic [3:0][bev_pkg::ING_W-1:0]    supplies,
    input  bev_pkg::dram_rsp_t                dram_rsp,
    input  logic                              compute_en,
    output bev_pkg::bev_record_t              record,
    output bev_pkg::error_msg_t               err_msg,
    output logic                              complete
);

    bev_pkg::recipe_t                     rcp;
    logic [7:0]                           qvol;
    logic [3:0][bev_pkg::ING_W-1:0]       stock;
    logic [3:0][2:0]                      quarters;
    logic [10:0]                          draw [4];
    logic signed [bev_pkg::ING_W:0]       diff [4];
    logic [bev_pkg::ING_W:0]              sum [4];
    logic [3:0][bev_pkg::ING_W-1:0]       clamped;
    logic [3:0]                           short;
    logic [3:0]                           over;
    logic                                 expired;

    assign rcp = bev_pkg::RECIPE[btype];

    // Lane order is black tea, green tea, milk, pineapple juice
    assign stock    = {record.pineapple_juice, record.milk, record.green_tea, record.black_tea};
    assign quarters = {rcp.pineapple_juice, rcp.milk, rcp.green_tea, rcp.black_tea};

    always_comb
    begin
        case (size)
            bev_pkg::size_l: qvol = 8'(bev_pkg::VOL_L / 4);
            bev_pkg::size_m: qvol = 8'(bev_pkg::VOL_M / 4);
            default:         qvol = 8'(bev_pkg::VOL_S / 4);
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            draw[i]    = {3'b000, qvol} * {8'd0, quarters[i]};
            diff[i]    = $signed({1'b0, stock[i]}) - $signed({2'b00, draw[i]});
            short[i]   = diff[i] < 0;
            sum[i]     = {1'b0, stock[i]} + {1'b0, supplies[i]};
            over[i]    = sum[i] > {1'b0, bev_pkg::ING_MAX};
            clamped[i] = over[i] ? bev_pkg::ING_MAX : sum[i][bev_pkg::ING_W-1:0];
        end
    end

    // Stored date earlier than the order date
    assign expired = (record.month < {4'd0, month}) ||
                     (record.month == {4'd0, month} && record.day < {3'd0, day});

    always_comb
    begin
        err_msg = bev_pkg::no_err;
        case (act)
            bev_pkg::make_drink:
                if (expired)
                    err_msg = bev_pkg::no_exp;
                else if (|short)
                    err_msg = bev_pkg::no_ing;
            bev_pkg::supply:
                if (|over)
                    err_msg = bev_pkg::ing_of;
            bev_pkg::check_valid_date:
                if (expired)
                    err_msg = bev_pkg::no_exp;
            default:
                err_msg = bev_pkg::no_err;
        endcase
    end

    assign complete = (err_msg == bev_pkg::no_err);

    always_ff @(posedge clk)
    begin
        if (dram_rsp.out_valid)
            record <= dram_rsp.data_r;
        else if (compute_en && act == bev_pkg::make_drink)
        begin
            record.black_tea       <= diff[0][bev_pkg::ING_W-1:0];
            record.green_tea       <= diff[1][bev_pkg::ING_W-1:0];
            record.milk            <= diff[2][bev_pkg::ING_W-1:0];
            record.pineapple_juice <= diff[3][bev_pkg::ING_W-1:0];
        end
        else if (compute_en && act == bev_pkg::supply)
        begin
            record.black_tea       <= clamped[0];
            record.green_tea       <= clamped[1];
            record.milk            <= clamped[2];
            record.pineapple_juice <= clamped[3];
            record.month           <= {4'd0, month};
            record.day             <= {3'd0, day};
        end
    end

endmodule

// ==== hw/bev_order_regs.sv ====
module bev_order_regs (
    input  logic                              clk,
    input  logic                              inf,
    input  bev_pkg::capture_t                 capture,
    input  bev_pkg::order_word_t              d,
    output bev_pkg::action_t                  act,
    output bev_pkg::bev_type_t                btype,
    output bev_pkg::bev_size_t                size,
    output logic [3:0]                        month,
    output logic [4:0]                        day,
    output logic [7:0]                        box_no,
    output logic [3:0][bev_pkg::ING_W-1:0]    supplies,
    output logic                              supplies_full
);

    logic [1:0] sup_cnt;

    // Order fields
    always_ff @(posedge clk)
    begin
        if (capture.act)
            act <= bev_pkg::action_t'(d[1:0]);
        if (capture.btype)
            btype <= bev_pkg::bev_type_t'(d[2:0]);
        if (capture.size)
            size <= bev_pkg::bev_size_t'(d[1:0]);
        if (capture.date)
        begin
            month <= d[8:5];
            day   <= d[4:0];
        end
        if (capture.box)
            box_no <= d[7:0];
        if (capture.sup)
            supplies[sup_cnt] <= d;
    end

    // Supply word steering, black tea first
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            sup_cnt       <= 2'd0;
            supplies_full <= 1'b0;
        end
        else if (capture.act)
        begin
            sup_cnt       <= 2'd0;
            supplies_full <= 1'b0;
        end
        else if (capture.sup)
        begin
            sup_cnt <= sup_cnt + 2'd1;
            if (sup_cnt == 2'd3)
                supplies_full <= 1'b1;
        end
    end

endmodule

// ==== hw/bev_ctrl.sv ====
module bev_ctrl (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  logic                  type_valid,
    input  logic                  size_valid,
    input  logic                  date_valid,
    input  logic                  box_no_valid,
    input  logic                  box_sup_valid,
    input  logic                  supplies_full,
    input  logic                  write_pending,
    input  bev_pkg::order_word_t  d,
    input  bev_pkg::action_t      act,
    input  logic                  read_done,
    input  bev_pkg::error_msg_t   err_msg,
    input  logic                  complete,
    output bev_pkg::capture_t     capture,
    output logic                  rd_start,
    output logic                  wr_start,
    output logic                  compute_en,
    output bev_pkg::bev_result_t  result
);

    bev_pkg::state_t  state;
    bev_pkg::state_t  next_state;
    bev_pkg::action_t new_act;
    logic             need_wb;

    assign new_act = bev_pkg::action_t'(d[1:0]);

    // Write back on a good drink or on any supply
    assign need_wb = (act == bev_pkg::supply) ||
                     (act == bev_pkg::make_drink && err_msg == bev_pkg::no_err);

    always_comb
    begin
        capture.act   = (state == bev_pkg::idle) && sel_action_valid;
        capture.btype = (state == bev_pkg::get_type) && type_valid;
        capture.size  = (state == bev_pkg::get_size) && size_valid;
        capture.date  = (state == bev_pkg::get_date) && date_valid;
        capture.box   = (state == bev_pkg::get_box) && box_no_valid;
        capture.sup   = (state == bev_pkg::get_supplies) && box_sup_valid;
    end

    assign rd_start   = (state == bev_pkg::wait_bridge) && !write_pending;
    assign wr_start   = (state == bev_pkg::write_back);
    assign compute_en = (state == bev_pkg::compute);

    always_comb
    begin
        next_state = state;
        case (state)
            bev_pkg::idle:
                if (capture.act)
                    next_state = (new_act == bev_pkg::make_drink) ? bev_pkg::get_type
                                                                 : bev_pkg::get_date;
            bev_pkg::get_type:
                if (capture.btype)
                    next_state = bev_pkg::get_size;
            bev_pkg::get_size:
                if (capture.size)
                    next_state = bev_pkg::get_date;
            bev_pkg::get_date:
                if (capture.date)
                    next_state = bev_pkg::get_box;
            bev_pkg::get_box:
                if (capture.box)
                    next_state = (act == bev_pkg::supply) ? bev_pkg::get_supplies
                                                          : bev_pkg::wait_bridge;
            bev_pkg::get_supplies:
                if (supplies_full)
                    next_state = bev_pkg::wait_bridge;
            // Hold here until the previous write is answered
            bev_pkg::wait_bridge:
                if (rd_start)
                    next_state = bev_pkg::read_dram;
            bev_pkg::read_dram:
                if (read_done)
                    next_state = bev_pkg::compute;
            bev_pkg::compute:
                next_state = need_wb ? bev_pkg::write_back : bev_pkg::idle;
            bev_pkg::write_back:
                next_state = bev_pkg::idle;
            default:
                next_state = bev_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            state <= bev_pkg::idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            result.out_valid <= 1'b0;
            result.err_msg   <= bev_pkg::no_err;
            result.complete  <= 1'b0;
        end
        else if (state == bev_pkg::compute)
        begin
            result.out_valid <= 1'b1;
            result.err_msg   <= err_msg;
            result.complete  <= complete;
        end
        else
        begin
            result.out_valid <= 1'b0;
            result.err_msg   <= bev_pkg::no_err;
            result.complete  <= 1'b0;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!inf)
        $onehot0({sel_action_valid, type_valid, size_valid,
                  date_valid, box_no_valid, box_sup_valid}));

    // Bridge answers only a read in flight or a pending write
    a_expected_response: assert property (@(posedge clk) disable iff (!inf)
        read_done |-> (state == bev_pkg::read_dram) || write_pending);

endmodule

// ==== hw/bev_pkg.sv ====
package bev_pkg;

    localparam int ING_W = 12;
    localparam logic [ING_W-1:0] ING_MAX = 12'd4095;

    // Cup volumes
    localparam int VOL_S = 480;
    localparam int VOL_M = 720;
    localparam int VOL_L = 960;

    typedef enum logic [1:0] {
        make_drink,
        supply,
        check_valid_date
    } action_t;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    typedef enum logic [1:0] {
        size_l,
        size_m,
        size_s
    } bev_size_t;

    typedef enum logic [1:0] {
        no_err,
        no_exp,
        no_ing,
        ing_of
    } error_msg_t;

    typedef enum logic [3:0] {
        idle,
        get_type,
        get_size,
        get_date,
        get_box,
        get_supplies,
        wait_bridge,
        read_dram,
        compute,
        write_back
    } state_t;

    // Date word is month in [8:5], day in [4:0]
    typedef logic [ING_W-1:0] order_word_t;

    typedef struct packed {
        logic [ING_W-1:0] black_tea;
        logic [ING_W-1:0] green_tea;
        logic [7:0]       month;
        logic [ING_W-1:0] milk;
        logic [ING_W-1:0] pineapple_juice;
        logic [7:0]       day;
    } bev_record_t;

    typedef struct packed {
        logic        in_valid;
        logic        r_wb;
        logic [7:0]  addr;
        bev_record_t data_w;
    } dram_req_t;

    typedef struct packed {
        logic        out_valid;
        bev_record_t data_r;
    } dram_rsp_t;

    typedef struct packed {
        logic       out_valid;
        error_msg_t err_msg;
        logic       complete;
    } bev_result_t;

    typedef struct packed {
        logic act;
        logic btype;
        logic size;
        logic date;
        logic box;
        logic sup;
    } capture_t;

    // Quarters of the cup volume per ingredient
    typedef struct packed {
        logic [2:0] black_tea;
        logic [2:0] green_tea;
        logic [2:0] milk;
        logic [2:0] pineapple_juice;
    } recipe_t;

    localparam recipe_t RECIPE [8] = '{
        '{3'd4, 3'd0, 3'd0, 3'd0},
        '{3'd3, 3'd0, 3'd1, 3'd0},
        '{3'd2, 3'd0, 3'd2, 3'd0},
        '{3'd0, 3'd4, 3'd0, 3'd0},
        '{3'd0, 3'd2, 3'd2, 3'd0},
        '{3'd0, 3'd0, 3'd0, 3'd4},
        '{3'd2, 3'd0, 3'd0, 3'd2},
        '{3'd2, 3'd0, 3'd1, 3'd1}
    };

endpackage
